// File: rtl/exu_pkg.sv
package exu_pkg;

   // register index
   localparam int REG_ADDR_W = 5;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // default data and pc width
   localparam int DEF_DATA_W = 32;

   // size of one instruction in bytes
   localparam int LINK_STEP = 4;

   localparam int ALU_OP_W = 4;
   typedef enum logic [ALU_OP_W-1:0] {
      alu_add  = 4'h0,
      alu_sub  = 4'h1,
      alu_slt  = 4'h2,
      alu_sltu = 4'h3,
      alu_and  = 4'h4,
      alu_or   = 4'h5,
      alu_xor  = 4'h6,
      alu_nor  = 4'h7,
      alu_sll  = 4'h8,
      alu_srl  = 4'h9,
      alu_sra  = 4'ha,
      alu_lui  = 4'hb
   } alu_op_t;

   localparam int BRU_OP_W = 4;
   // b, bl and jirl are unconditional
   typedef enum logic [BRU_OP_W-1:0] {
      bru_beq  = 4'h0,
      bru_bne  = 4'h1,
      bru_blt  = 4'h2,
      bru_bge  = 4'h3,
      bru_bltu = 4'h4,
      bru_bgeu = 4'h5,
      bru_b    = 4'h6,
      bru_bl   = 4'h7,
      bru_jirl = 4'h8
   } bru_op_t;

endpackage

// File: rtl/exu_regfile.sv
`timescale 1ns/10ps

module exu_regfile #(
   parameter int DATA_W = exu_pkg::DEF_DATA_W
) (
   input  logic               clk,
   input  exu_pkg::reg_addr_t raddr0,
   input  exu_pkg::reg_addr_t raddr1,
   input  logic               wen,
   input  exu_pkg::reg_addr_t waddr,
   input  logic [DATA_W-1:0]  wdata,
   output logic [DATA_W-1:0]  rdata0,
   output logic [DATA_W-1:0]  rdata1
);

   localparam int DEPTH = 2 ** exu_pkg::REG_ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[waddr] <= wdata;
      end
   end

   // r0 reads as zero and a same-cycle write is passed through
   assign rdata0 = (raddr0 == '0)                ? '0    :
                   (wen && (raddr0 == waddr))    ? wdata :
                                                   mem[raddr0];
   assign rdata1 = (raddr1 == '0)                ? '0    :
                   (wen && (raddr1 == waddr))    ? wdata :
                                                   mem[raddr1];

endmodule

// File: rtl/exu_bypass.sv
`timescale 1ns/10ps

module exu_bypass #(
   parameter int DATA_W = exu_pkg::DEF_DATA_W
) (
   input  exu_pkg::reg_addr_t rs1_e,
   input  exu_pkg::reg_addr_t rs2_e,
   input  logic [DATA_W-1:0]  rs1_data_e,
   input  logic [DATA_W-1:0]  rs2_data_e,
   input  exu_pkg::reg_addr_t rd_m,
   input  logic               wen_m,
   input  logic [DATA_W-1:0]  rd_data_m,
   input  exu_pkg::reg_addr_t rd_w,
   input  logic               wen_w,
   input  logic [DATA_W-1:0]  rd_data_w,
   output logic [DATA_W-1:0]  rs1_data_byp,
   output logic [DATA_W-1:0]  rs2_data_byp
);

   // m stage is younger, so it wins over w
   assign rs1_data_byp = (rs1_e == '0)               ? rs1_data_e :
                         (wen_m && (rd_m == rs1_e))  ? rd_data_m  :
                         (wen_w && (rd_w == rs1_e))  ? rd_data_w  :
                                                       rs1_data_e;
   assign rs2_data_byp = (rs2_e == '0)               ? rs2_data_e :
                         (wen_m && (rd_m == rs2_e))  ? rd_data_m  :
                         (wen_w && (rd_w == rs2_e))  ? rd_data_w  :
                                                       rs2_data_e;

endmodule

// File: rtl/exu_alu.sv
`timescale 1ns/10ps

module exu_alu #(
   parameter int DATA_W = exu_pkg::DEF_DATA_W
) (
   input  logic [DATA_W-1:0] a,
   input  logic [DATA_W-1:0] b,
   input  exu_pkg::alu_op_t  op,
   output logic [DATA_W-1:0] result
);

   logic [4:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;

   // shift amount is always the low five bits of b
   assign shamt = b[4:0];

   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      case (op)
         exu_pkg::alu_add: begin
            result = a + b;
         end
         exu_pkg::alu_sub: begin
            result = a - b;
         end
         exu_pkg::alu_slt: begin
            result = {{(DATA_W-1){1'b0}}, lt_signed};
         end
         exu_pkg::alu_sltu: begin
            result = {{(DATA_W-1){1'b0}}, lt_unsigned};
         end
         exu_pkg::alu_and: begin
            result = a & b;
         end
         exu_pkg::alu_or: begin
            result = a | b;
         end
         exu_pkg::alu_xor: begin
            result = a ^ b;
         end
         exu_pkg::alu_nor: begin
            result = ~(a | b);
         end
         exu_pkg::alu_sll: begin
            result = a << shamt;
         end
         exu_pkg::alu_srl: begin
            result = a >> shamt;
         end
         exu_pkg::alu_sra: begin
            result = $signed(a) >>> shamt;
         end
         // immediate already shifted by decode
         exu_pkg::alu_lui: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// File: rtl/exu_branch.sv
`timescale 1ns/10ps

module exu_branch #(
   parameter int DATA_W = exu_pkg::DEF_DATA_W
) (
   input  logic              vld,
   input  exu_pkg::bru_op_t  op,
   input  logic [DATA_W-1:0] a,
   input  logic [DATA_W-1:0] b,
   input  logic [DATA_W-1:0] pc,
   input  logic [DATA_W-1:0] offset,
   output logic              taken,
   output logic [DATA_W-1:0] target,
   output logic [DATA_W-1:0] link_pc
);

   logic cond;
   logic eq;
   logic lt_s;
   logic lt_u;

   assign eq   = a == b;
   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   always_comb begin
      case (op)
         exu_pkg::bru_beq:  cond = eq;
         exu_pkg::bru_bne:  cond = !eq;
         exu_pkg::bru_blt:  cond = lt_s;
         exu_pkg::bru_bge:  cond = !lt_s;
         exu_pkg::bru_bltu: cond = lt_u;
         exu_pkg::bru_bgeu: cond = !lt_u;
         exu_pkg::bru_b,
         exu_pkg::bru_bl,
         exu_pkg::bru_jirl: cond = 1'b1;
         default:           cond = 1'b0;
      endcase
   end

   assign taken = vld & cond;

   // jirl is register relative, everything else pc relative
   assign target = ((op == exu_pkg::bru_jirl) ? a : pc) + offset;

   assign link_pc = pc + DATA_W'(exu_pkg::LINK_STEP);

endmodule

// File: rtl/exu_core.sv
`timescale 1ns/10ps

module exu_core #(
   parameter int DATA_W = exu_pkg::DEF_DATA_W
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               vld_d,
   input  logic [DATA_W-1:0]  pc_d,
   input  logic [DATA_W-1:0]  imm_d,
   input  exu_pkg::reg_addr_t rs1_d,
   input  exu_pkg::reg_addr_t rs2_d,
   input  exu_pkg::reg_addr_t rd_d,
   input  logic               wen_d,
   input  logic               alu_vld_d,
   input  exu_pkg::alu_op_t   alu_op_d,
   input  logic               alu_a_pc_d,
   input  logic               alu_b_imm_d,
   input  logic               bru_vld_d,
   input  exu_pkg::bru_op_t   bru_op_d,
   input  logic [DATA_W-1:0]  bru_offset_d,
   output logic               branch,
   output logic [DATA_W-1:0]  brn_addr,
   output logic               wb_vld,
   output exu_pkg::reg_addr_t wb_rd,
   output logic [DATA_W-1:0]  wb_data
);

   logic [DATA_W-1:0]  rs1_data_d;
   logic [DATA_W-1:0]  rs2_data_d;
   logic               flush;
   logic               issue;

   // e stage
   logic [DATA_W-1:0]  pc_e;
   logic [DATA_W-1:0]  imm_e;
   exu_pkg::reg_addr_t rs1_e;
   exu_pkg::reg_addr_t rs2_e;
   exu_pkg::reg_addr_t rd_e;
   logic [DATA_W-1:0]  rs1_data_e;
   logic [DATA_W-1:0]  rs2_data_e;
   logic [DATA_W-1:0]  rs1_byp_e;
   logic [DATA_W-1:0]  rs2_byp_e;
   logic               wen_e;
   logic               alu_vld_e;
   exu_pkg::alu_op_t   alu_op_e;
   logic               alu_a_pc_e;
   logic               alu_b_imm_e;
   logic [DATA_W-1:0]  alu_a_e;
   logic [DATA_W-1:0]  alu_b_e;
   logic [DATA_W-1:0]  alu_res_e;
   logic               bru_vld_e;
   exu_pkg::bru_op_t   bru_op_e;
   logic [DATA_W-1:0]  bru_offset_e;
   logic               taken_e;
   logic [DATA_W-1:0]  target_e;
   logic [DATA_W-1:0]  link_pc_e;

   // m stage
   exu_pkg::reg_addr_t rd_m;
   logic               wen_m;
   logic               alu_vld_m;
   logic               bru_vld_m;
   logic               taken_m;
   logic [DATA_W-1:0]  alu_res_m;
   logic [DATA_W-1:0]  link_pc_m;
   logic [DATA_W-1:0]  target_m;
   logic [DATA_W-1:0]  rd_data_m;

   // w stage
   exu_pkg::reg_addr_t rd_w;
   logic               wen_w;
   logic               taken_w;
   logic [DATA_W-1:0]  rd_data_w;
   logic [DATA_W-1:0]  target_w;

   // any taken branch still in flight kills the slot in d
   assign flush = taken_e | taken_m | taken_w;
   assign issue = vld_d & ~flush;

   exu_regfile #(.DATA_W(DATA_W)) u_rf (
      .clk    (clk),
      .raddr0 (rs1_d),
      .raddr1 (rs2_d),
      .wen    (wen_w),
      .waddr  (rd_w),
      .wdata  (rd_data_w),
      .rdata0 (rs1_data_d),
      .rdata1 (rs2_data_d)
   );

   exu_bypass #(.DATA_W(DATA_W)) u_byp (
      .rs1_e        (rs1_e),
      .rs2_e        (rs2_e),
      .rs1_data_e   (rs1_data_e),
      .rs2_data_e   (rs2_data_e),
      .rd_m         (rd_m),
      .wen_m        (wen_m),
      .rd_data_m    (rd_data_m),
      .rd_w         (rd_w),
      .wen_w        (wen_w),
      .rd_data_w    (rd_data_w),
      .rs1_data_byp (rs1_byp_e),
      .rs2_data_byp (rs2_byp_e)
   );

   assign alu_a_e = alu_a_pc_e ? pc_e : rs1_byp_e;
   assign alu_b_e = alu_b_imm_e ? imm_e : rs2_byp_e;

   exu_alu #(.DATA_W(DATA_W)) u_alu (
      .a      (alu_a_e),
      .b      (alu_b_e),
      .op     (alu_op_e),
      .result (alu_res_e)
   );

   exu_branch #(.DATA_W(DATA_W)) u_bru (
      .vld     (bru_vld_e),
      .op      (bru_op_e),
      .a       (rs1_byp_e),
      .b       (rs2_byp_e),
      .pc      (pc_e),
      .offset  (bru_offset_e),
      .taken   (taken_e),
      .target  (target_e),
      .link_pc (link_pc_e)
   );

   // only one unit is valid per instruction
   assign rd_data_m = ({DATA_W{alu_vld_m}} & alu_res_m) |
                      ({DATA_W{bru_vld_m}} & link_pc_m);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wen_e     <= 1'b0;
         alu_vld_e <= 1'b0;
         bru_vld_e <= 1'b0;
         wen_m     <= 1'b0;
         alu_vld_m <= 1'b0;
         bru_vld_m <= 1'b0;
         taken_m   <= 1'b0;
         rd_m      <= '0;
         wen_w     <= 1'b0;
         taken_w   <= 1'b0;
         rd_w      <= '0;
      end else begin
         wen_e     <= wen_d & issue;
         alu_vld_e <= alu_vld_d & issue;
         bru_vld_e <= bru_vld_d & issue;
         wen_m     <= wen_e;
         alu_vld_m <= alu_vld_e;
         bru_vld_m <= bru_vld_e;
         taken_m   <= taken_e;
         rd_m      <= rd_e;
         wen_w     <= wen_m;
         taken_w   <= taken_m;
         rd_w      <= rd_m;
      end
   end

   // payload is qualified by the flags above
   always_ff @(posedge clk) begin
      pc_e         <= pc_d;
      imm_e        <= imm_d;
      rs1_e        <= rs1_d;
      rs2_e        <= rs2_d;
      rd_e         <= rd_d;
      rs1_data_e   <= rs1_data_d;
      rs2_data_e   <= rs2_data_d;
      alu_op_e     <= alu_op_d;
      alu_a_pc_e   <= alu_a_pc_d;
      alu_b_imm_e  <= alu_b_imm_d;
      bru_op_e     <= bru_op_d;
      bru_offset_e <= bru_offset_d;
      alu_res_m    <= alu_res_e;
      link_pc_m    <= link_pc_e;
      target_m     <= target_e;
      rd_data_w    <= rd_data_m;
      target_w     <= target_m;
   end

   assign branch   = taken_w;
   assign brn_addr = target_w;
   assign wb_vld   = wen_w;
   assign wb_rd    = rd_w;
   assign wb_data  = rd_data_w;

endmodule

// File: tests/tb_exu_core.sv
`timescale 1ns/10ps

module tb_exu_core;

   localparam int DATA_W     = exu_pkg::DEF_DATA_W;
   localparam int CLK_PERIOD = 100;
   localparam int DRV_DLY    = 5;
   localparam int TIMEOUT    = 20;
   localparam int RETIRE_LAT = 3;

   logic               clk;
   logic               arst_n;
   logic               vld_d;
   logic [DATA_W-1:0]  pc_d;
   logic [DATA_W-1:0]  imm_d;
   exu_pkg::reg_addr_t rs1_d;
   exu_pkg::reg_addr_t rs2_d;
   exu_pkg::reg_addr_t rd_d;
   logic               wen_d;
   logic               alu_vld_d;
   exu_pkg::alu_op_t   alu_op_d;
   logic               alu_a_pc_d;
   logic               alu_b_imm_d;
   logic               bru_vld_d;
   exu_pkg::bru_op_t   bru_op_d;
   logic [DATA_W-1:0]  bru_offset_d;
   logic               branch;
   logic [DATA_W-1:0]  brn_addr;
   logic               wb_vld;
   exu_pkg::reg_addr_t wb_rd;
   logic [DATA_W-1:0]  wb_data;

   // expected results in retire order
   exu_pkg::reg_addr_t wb_rd_q [$];
   logic [DATA_W-1:0]  wb_data_q [$];
   logic [DATA_W-1:0]  br_q [$];

   // edge count and the cycle each expected event is due
   int unsigned        cyc;
   int unsigned        issue_cyc;
   int unsigned        wb_cyc_q [$];
   int unsigned        br_cyc_q [$];

   // fields of one issue line
   logic [DATA_W-1:0]  fld [14];

   exu_core #(.DATA_W(DATA_W)) exu_core_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .vld_d        (vld_d),
      .pc_d         (pc_d),
      .imm_d        (imm_d),
      .rs1_d        (rs1_d),
      .rs2_d        (rs2_d),
      .rd_d         (rd_d),
      .wen_d        (wen_d),
      .alu_vld_d    (alu_vld_d),
      .alu_op_d     (alu_op_d),
      .alu_a_pc_d   (alu_a_pc_d),
      .alu_b_imm_d  (alu_b_imm_d),
      .bru_vld_d    (bru_vld_d),
      .bru_op_d     (bru_op_d),
      .bru_offset_d (bru_offset_d),
      .branch       (branch),
      .brn_addr     (brn_addr),
      .wb_vld       (wb_vld),
      .wb_rd        (wb_rd),
      .wb_data      (wb_data)
   );

   initial begin
      clk = 1'b0;
      cyc = 0;
   end

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic clear_issue();
      vld_d        = 1'b0;
      pc_d         = '0;
      imm_d        = '0;
      rs1_d        = '0;
      rs2_d        = '0;
      rd_d         = '0;
      wen_d        = 1'b0;
      alu_vld_d    = 1'b0;
      alu_op_d     = exu_pkg::alu_add;
      alu_a_pc_d   = 1'b0;
      alu_b_imm_d  = 1'b0;
      bru_vld_d    = 1'b0;
      bru_op_d     = exu_pkg::bru_beq;
      bru_offset_d = '0;
   endtask

   task automatic apply_issue();
      vld_d        = fld[0][0];
      pc_d         = fld[1];
      imm_d        = fld[2];
      rs1_d        = fld[3][exu_pkg::REG_ADDR_W-1:0];
      rs2_d        = fld[4][exu_pkg::REG_ADDR_W-1:0];
      rd_d         = fld[5][exu_pkg::REG_ADDR_W-1:0];
      wen_d        = fld[6][0];
      alu_vld_d    = fld[7][0];
      alu_op_d     = exu_pkg::alu_op_t'(fld[8][exu_pkg::ALU_OP_W-1:0]);
      alu_a_pc_d   = fld[9][0];
      alu_b_imm_d  = fld[10][0];
      bru_vld_d    = fld[11][0];
      bru_op_d     = exu_pkg::bru_op_t'(fld[12][exu_pkg::BRU_OP_W-1:0]);
      bru_offset_d = fld[13];
   endtask

   task automatic check_wb(input exu_pkg::reg_addr_t rd, input logic [DATA_W-1:0] data);
      exu_pkg::reg_addr_t exp_rd;
      logic [DATA_W-1:0]  exp_data;
      int unsigned        exp_cyc;
      if (wb_rd_q.size() == 0) begin
         stop_on_error($sformatf("write-back to x%0d at %0t was not expected", rd, $time));
      end else begin
         exp_rd   = wb_rd_q.pop_front();
         exp_data = wb_data_q.pop_front();
         exp_cyc  = wb_cyc_q.pop_front();
         if ((rd !== exp_rd) || (data !== exp_data)) begin
            stop_on_error($sformatf("FAIL %0t: write-back x%0d = %h, expected x%0d = %h",
                                    $time, rd, data, exp_rd, exp_data));
         end else if (cyc != exp_cyc) begin
            stop_on_error($sformatf("FAIL %0t: write-back x%0d in cycle %0d, expected %0d",
                                    $time, rd, cyc, exp_cyc));
         end
      end
   endtask

   task automatic check_branch(input logic [DATA_W-1:0] target);
      logic [DATA_W-1:0] exp_target;
      int unsigned       exp_cyc;
      if (br_q.size() == 0) begin
         stop_on_error($sformatf("branch to %h at %0t was not expected", target, $time));
      end else begin
         exp_target = br_q.pop_front();
         exp_cyc    = br_cyc_q.pop_front();
         if (target !== exp_target) begin
            stop_on_error($sformatf("FAIL %0t: branch target %h, expected %h",
                                    $time, target, exp_target));
         end else if (cyc != exp_cyc) begin
            stop_on_error($sformatf("FAIL %0t: branch in cycle %0d, expected %0d",
                                    $time, cyc, exp_cyc));
         end
      end
   endtask

   // outputs settle well before the falling edge
   always @(negedge clk) begin
      if (arst_n) begin
         if (wb_vld) begin
            check_wb(wb_rd, wb_data);
         end
         if (branch) begin
            check_branch(brn_addr);
         end
      end
   end

   initial begin
      int                fd;
      int                n;
      int                wait_cnt;
      logic [63:0]       tag;
      logic [8*128-1:0]  rest;
      logic [DATA_W-1:0] exp_rd;
      logic [DATA_W-1:0] exp_val;
      clear_issue();
      arst_n    = 1'b0;
      issue_cyc = 0;
      fd = $fopen("tests/exu_patterns.txt", "r");
      if (fd == 0) begin
         stop_on_error("could not open the pattern file tests/exu_patterns.txt");
      end
      repeat (5) @(posedge clk);
      #DRV_DLY;
      arst_n = 1'b1;
      while (!$feof(fd)) begin
         n = $fscanf(fd, "%s", tag);
         if (n == 1) begin
            if (tag == "I") begin
               n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                           fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
               if (n != 14) begin
                  stop_on_error("an issue line in the pattern file is incomplete");
               end else begin
                  @(posedge clk);
                  #DRV_DLY;
                  apply_issue();
                  issue_cyc = cyc;
               end
            end else if (tag == "W") begin
               n = $fscanf(fd, "%h %h", exp_rd, exp_val);
               wb_rd_q.push_back(exp_rd[exu_pkg::REG_ADDR_W-1:0]);
               wb_data_q.push_back(exp_val);
               wb_cyc_q.push_back(issue_cyc + RETIRE_LAT);
            end else if (tag == "L") begin
               // link write-back is the branch pc plus one instruction
               n = $fscanf(fd, "%h %h", exp_rd, exp_val);
               wb_rd_q.push_back(exp_rd[exu_pkg::REG_ADDR_W-1:0]);
               wb_data_q.push_back(exp_val + DATA_W'(exu_pkg::LINK_STEP));
               wb_cyc_q.push_back(issue_cyc + RETIRE_LAT);
            end else if (tag == "B") begin
               n = $fscanf(fd, "%h", exp_val);
               br_q.push_back(exp_val);
               br_cyc_q.push_back(issue_cyc + RETIRE_LAT);
            end else if (tag == "#") begin
               n = $fgets(rest, fd);
            end else begin
               stop_on_error("the pattern file holds a line with an unknown tag");
            end
         end
      end
      $fclose(fd);
      @(posedge clk);
      #DRV_DLY;
      clear_issue();
      wait_cnt = 0;
      while (((wb_rd_q.size() != 0) || (br_q.size() != 0)) && (wait_cnt < TIMEOUT)) begin
         @(posedge clk);
         wait_cnt++;
      end
      // quiet cycles to catch stray retires
      repeat (4) @(posedge clk);
      if ((wb_rd_q.size() != 0) || (br_q.size() != 0)) begin
         stop_on_error($sformatf("timed out with %0d write-backs and %0d branches never seen",
                                 wb_rd_q.size(), br_q.size()));
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

// File: files.f
rtl/exu_pkg.sv
rtl/exu_regfile.sv
rtl/exu_bypass.sv
rtl/exu_alu.sv
rtl/exu_branch.sv
rtl/exu_core.sv
tests/tb_exu_core.sv

// File: tests/exu_patterns.txt
# I vld pc imm rs1 rs2 rd wen alu_vld alu_op a_pc b_imm bru_vld bru_op offset (all hex)
# W rd data = write-back, L rd pc = link write-back of pc + 4, B target = taken branch
I 0 00000000 00000000 00 00 00 0 0 0 0 0 0 0 00000000
I 1 00000100 12345000 00 00 01 1 1 b 0 1 0 0 00000000
W 01 12345000
I 1 00000104 00000678 00 00 02 1 1 0 0 1 0 0 00000000
W 02 00000678
I 1 00000108 00000000 01 02 03 1 1 5 0 0 0 0 00000000
W 03 12345678
I 1 0000010c 00000000 03 01 04 1 1 1 0 0 0 0 00000000
W 04 00000678
I 1 00000110 ffffffff 00 00 05 1 1 0 0 1 0 0 00000000
W 05 ffffffff
I 1 00000114 00000000 05 02 06 1 1 2 0 0 0 0 00000000
W 06 00000001
I 1 00000118 00000000 05 02 07 1 1 3 0 0 0 0 00000000
W 07 00000000
I 1 0000011c 0000ff00 03 00 08 1 1 4 0 1 0 0 00000000
W 08 00005600
I 1 00000120 00000000 03 05 09 1 1 6 0 0 0 0 00000000
W 09 edcba987
I 1 00000124 00000000 02 00 0a 1 1 7 0 0 0 0 00000000
W 0a fffff987
I 1 00000128 00000024 03 00 0b 1 1 8 0 1 0 0 00000000
W 0b 23456780
I 1 0000012c 00000008 05 00 0c 1 1 9 0 1 0 0 00000000
W 0c 00ffffff
I 1 00000130 00000004 09 00 0d 1 1 a 0 1 0 0 00000000
W 0d fedcba98
I 1 00000134 00000010 00 00 0e 1 1 0 1 1 0 0 00000000
W 0e 00000144
I 1 00000138 00000001 02 00 00 1 1 0 0 1 0 0 00000000
W 00 00000679
I 1 0000013c 00000000 00 02 0f 1 1 0 0 0 0 0 00000000
W 0f 00000678
I 1 00000140 00000000 04 02 00 0 0 0 0 0 1 0 00000040
B 00000180
I 1 00000144 0000dead 00 00 10 1 1 0 0 1 0 0 00000000
I 1 00000148 0000dead 00 00 10 1 1 0 0 1 0 0 00000000
I 1 0000014c 0000dead 00 00 10 1 1 0 0 1 0 0 00000000
I 1 00000180 00000000 00 00 11 1 0 0 0 0 1 7 00000080
L 11 00000180
B 00000200
I 1 00000184 0000dead 00 00 10 1 1 0 0 1 0 0 00000000
I 1 00000188 0000dead 00 00 10 1 1 0 0 1 0 0 00000000
I 1 0000018c 0000dead 00 00 10 1 1 0 0 1 0 0 00000000
I 1 00000200 00000000 11 00 12 1 0 0 0 0 1 8 00000020
L 12 00000200
B 000001a4
I 1 00000204 0000dead 00 00 10 1 1 0 0 1 0 0 00000000
I 1 00000208 0000dead 00 00 10 1 1 0 0 1 0 0 00000000
I 1 0000020c 0000dead 00 00 10 1 1 0 0 1 0 0 00000000
I 1 000001a4 00000000 04 02 00 0 0 0 0 0 1 1 00000100
I 1 000001a8 00000001 0c 00 13 1 1 0 0 1 0 0 00000000
W 13 01000000
I 1 000001ac 00000000 13 11 14 1 1 1 0 0 0 0 00000000
W 14 00fffe7c
I 1 000001b0 00000000 05 02 00 0 0 0 0 0 1 2 fffffff8
B 000001a8
